// File: flist.f
src/texcache_pkg.sv
src/texcache_tag.sv
src/texcache_mem_request.sv
src/texcache_r_fifo.sv
src/texcache_r_combiner.sv
src/texcache_data.sv
src/texcache_lookahead.sv
tb/texcache_asserts.sv
tb/texcache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module texcache_tb -f flist.f -o texcache_sim
./obj_dir/texcache_sim +verilator+error+limit+10

// File: src/texcache_data.sv
module texcache_data import texcache_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  pix_addr_t              s_addr,
    input  logic                   s_hit,
    input  logic                   s_valid,
    input  logic [pixel_width-1:0] fill_data,
    input  logic                   fill_last,
    input  logic                   fill_valid,
    input  logic                   s_rready,
    output logic                   s_ready,
    output logic                   fill_ready,
    output logic                   fill_done,
    output logic [pixel_width-1:0] s_rdata,
    output logic                   s_rvalid
);

    localparam int pix_idx_width = $clog2(blk_pix_num);

    pix_addr_t                          q_addr [que_depth];
    logic                               q_hit [que_depth];
    logic [$clog2(que_depth):0]         wr_ptr;
    logic [$clog2(que_depth):0]         rd_ptr;
    logic                               q_valid;
    pix_addr_t                          head_addr;
    logic                               head_hit;
    logic                               head_filled;
    logic [pix_idx_width-1:0]           fill_cnt;
    logic [pixel_width-1:0]             pix_ram [(1 << tag_addr_width) * blk_pix_num];
    logic [tag_addr_width+pix_idx_width-1:0] rd_addr;
    logic                               push;
    logic                               fill_we;
    logic                               rd_en;

    // ------------------------------------------------------------
    // access queue
    // ------------------------------------------------------------
    assign s_ready   = ((wr_ptr - rd_ptr) != ($clog2(que_depth) + 1)'(que_depth));
    assign push      = s_valid && s_ready;
    assign q_valid   = (wr_ptr != rd_ptr);
    assign head_addr = q_addr[rd_ptr[$clog2(que_depth)-1:0]];
    assign head_hit  = q_hit[rd_ptr[$clog2(que_depth)-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            q_addr[wr_ptr[$clog2(que_depth)-1:0]] <= s_addr;
            q_hit[wr_ptr[$clog2(que_depth)-1:0]]  <= s_hit;
        end
    end

    // ------------------------------------------------------------
    // block fill for a miss at the head
    // ------------------------------------------------------------
    assign fill_ready = q_valid && !head_hit && !head_filled;
    assign fill_we    = fill_valid && fill_ready;
    assign fill_done  = fill_we && fill_last;

    // beats come in raster order within the block
    always_ff @(posedge clk) begin
        if (fill_we) begin
            pix_ram[{line_of(head_addr), fill_cnt}] <= fill_data;
        end
    end

    // ------------------------------------------------------------
    // read and slave output
    // ------------------------------------------------------------
    assign rd_en   = q_valid && (head_hit || head_filled) && (!s_rvalid || s_rready);
    assign rd_addr = {line_of(head_addr), head_addr.field.pix_y, head_addr.field.pix_x};

    always_ff @(posedge clk) begin
        if (rd_en) begin
            s_rdata <= pix_ram[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            head_filled <= 1'b0;
            fill_cnt    <= '0;
            s_rvalid    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fill_we) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            if (fill_done) begin
                head_filled <= 1'b1;
                fill_cnt    <= '0;
            end
            // entry leaves the queue once its read is issued
            if (rd_en) begin
                rd_ptr      <= rd_ptr + 1'b1;
                head_filled <= 1'b0;
                s_rvalid    <= 1'b1;
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
        end
    end

endmodule

// File: src/texcache_lookahead.sv
module texcache_lookahead import texcache_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clear_start,
    output logic                     clear_busy,
    output logic                     status_hit,
    output logic                     status_miss,

    input  pix_addr_t                s_araddr,
    input  logic                     s_arvalid,
    output logic                     s_arready,
    output logic [pixel_width-1:0]   s_rdata,
    output logic                     s_rvalid,
    input  logic                     s_rready,

    output pix_addr_t                m_araddr,
    output logic                     m_arvalid,
    input  logic                     m_arready,
    input  logic [pixel_width-1:0]   m_rdata,
    input  logic [component_num-1:0] m_rstrb,
    input  logic                     m_rlast,
    input  logic                     m_rvalid,
    output logic                     m_rready
);

    pix_addr_t                              tag_addr;
    logic                                   tag_hit;
    logic                                   tag_valid;
    logic                                   tag_ready;
    pix_addr_t                              miss_addr;
    logic                                   miss_valid;
    logic                                   miss_ready;
    logic                                   fill_done;

    logic [component_num-1:0]               rfifo_s_ready;
    logic [component_num*component_width-1:0] rfifo_data;
    logic [component_num-1:0]               rfifo_last;
    logic [component_num-1:0]               rfifo_valid;
    logic [component_num-1:0]               rfifo_ready;

    logic [pixel_width-1:0]                 fill_data;
    logic                                   fill_last;
    logic                                   fill_valid;
    logic                                   fill_ready;

    texcache_tag u_tag (
        .clk         (clk),
        .reset       (reset),
        .clear_start (clear_start),
        .s_araddr    (s_araddr),
        .s_arvalid   (s_arvalid),
        .m_ready     (tag_ready),
        .miss_ready  (miss_ready),
        .s_arready   (s_arready),
        .clear_busy  (clear_busy),
        .m_addr      (tag_addr),
        .m_hit       (tag_hit),
        .m_valid     (tag_valid),
        .miss_addr   (miss_addr),
        .miss_valid  (miss_valid),
        .status_hit  (status_hit),
        .status_miss (status_miss)
    );

    texcache_mem_request u_mem_request (
        .clk        (clk),
        .reset      (reset),
        .miss_addr  (miss_addr),
        .miss_valid (miss_valid),
        .fill_done  (fill_done),
        .m_arready  (m_arready),
        .miss_ready (miss_ready),
        .m_araddr   (m_araddr),
        .m_arvalid  (m_arvalid)
    );

    // ------------------------------------------------------------
    // memory read data split into one FIFO per component
    // ------------------------------------------------------------
    assign m_rready = &rfifo_s_ready;

    for (genvar i = 0; i < component_num; i++) begin : r_fifo_loop
        texcache_r_fifo u_r_fifo (
            .clk     (clk),
            .reset   (reset),
            .s_data  (m_rdata[i*component_width +: component_width]),
            .s_last  (m_rlast),
            .s_valid (m_rvalid && m_rstrb[i] && m_rready),
            .m_ready (rfifo_ready[i]),
            .s_ready (rfifo_s_ready[i]),
            .m_data  (rfifo_data[i*component_width +: component_width]),
            .m_last  (rfifo_last[i]),
            .m_valid (rfifo_valid[i])
        );
    end

    texcache_r_combiner u_r_combiner (
        .clk     (clk),
        .reset   (reset),
        .s_data  (rfifo_data),
        .s_last  (rfifo_last),
        .s_valid (rfifo_valid),
        .m_ready (fill_ready),
        .s_ready (rfifo_ready),
        .m_data  (fill_data),
        .m_last  (fill_last),
        .m_valid (fill_valid)
    );

    texcache_data u_data (
        .clk        (clk),
        .reset      (reset),
        .s_addr     (tag_addr),
        .s_hit      (tag_hit),
        .s_valid    (tag_valid),
        .fill_data  (fill_data),
        .fill_last  (fill_last),
        .fill_valid (fill_valid),
        .s_rready   (s_rready),
        .s_ready    (tag_ready),
        .fill_ready (fill_ready),
        .fill_done  (fill_done),
        .s_rdata    (s_rdata),
        .s_rvalid   (s_rvalid)
    );

endmodule

// File: src/texcache_mem_request.sv
module texcache_mem_request import texcache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  pix_addr_t miss_addr,
    input  logic      miss_valid,
    input  logic      fill_done,
    input  logic      m_arready,
    output logic      miss_ready,
    output pix_addr_t m_araddr,
    output logic      m_arvalid
);

    pix_addr_t                              ar_mem [ar_fifo_depth];
    logic [$clog2(ar_fifo_depth):0]         wr_ptr;
    logic [$clog2(ar_fifo_depth):0]         rd_ptr;
    logic [$clog2(look_ahead_num+1)-1:0]    out_cnt;
    logic                                   empty;
    logic                                   push;
    logic                                   pop;

    // ------------------------------------------------------------
    // address FIFO
    // ------------------------------------------------------------
    assign empty      = (wr_ptr == rd_ptr);
    assign miss_ready = ((wr_ptr - rd_ptr) != ($clog2(ar_fifo_depth) + 1)'(ar_fifo_depth));
    assign push       = miss_valid && miss_ready;

    // head held back while too many blocks are in flight
    assign m_arvalid  = !empty && (out_cnt < look_ahead_num);
    assign m_araddr   = ar_mem[rd_ptr[$clog2(ar_fifo_depth)-1:0]];
    assign pop        = m_arvalid && m_arready;

    always_ff @(posedge clk) begin
        if (push) begin
            ar_mem[wr_ptr[$clog2(ar_fifo_depth)-1:0]] <= miss_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // outstanding read limiter
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            out_cnt <= '0;
        end else begin
            case ({pop, fill_done})
                2'b10:   out_cnt <= out_cnt + 1'b1;
                2'b01:   out_cnt <= out_cnt - 1'b1;
                default: out_cnt <= out_cnt;
            endcase
        end
    end

endmodule

// File: src/texcache_pkg.sv
package texcache_pkg;

    // ------------------------------------------------------------
    // texture and block geometry
    // ------------------------------------------------------------
    localparam int addr_x_width     = 8;
    localparam int addr_y_width     = 8;
    localparam int blk_x_size       = 1;
    localparam int blk_y_size       = 1;
    localparam int blk_pix_num      = 1 << (blk_x_size + blk_y_size);
    localparam int blk_addr_x_width = addr_x_width - blk_x_size;
    localparam int blk_addr_y_width = addr_y_width - blk_y_size;

    // cache lines and tags
    localparam int tag_addr_width   = 4;
    localparam int line_x_width     = tag_addr_width / 2;
    localparam int line_y_width     = tag_addr_width - line_x_width;
    localparam int tag_width        = blk_addr_x_width + blk_addr_y_width - tag_addr_width;

    // pixel format
    localparam int component_num    = 3;
    localparam int component_width  = 8;
    localparam int pixel_width      = component_num * component_width;

    // queue and FIFO sizes
    localparam int look_ahead_num   = 2;
    localparam int que_depth        = 8;
    localparam int ar_fifo_depth    = 4;
    localparam int r_fifo_depth     = 8;

    typedef struct packed {
        logic [addr_y_width-1:0] y;
        logic [addr_x_width-1:0] x;
    } pix_raw_t;

    typedef struct packed {
        logic [blk_addr_y_width-1:0] blk_y;
        logic [blk_y_size-1:0]       pix_y;
        logic [blk_addr_x_width-1:0] blk_x;
        logic [blk_x_size-1:0]       pix_x;
    } pix_field_t;

    typedef union packed {
        pix_raw_t   raw;
        pix_field_t field;
    } pix_addr_t;

    // low block bits pick the line
    function automatic logic [tag_addr_width-1:0] line_of(pix_addr_t a);
        return {a.field.blk_y[line_y_width-1:0], a.field.blk_x[line_x_width-1:0]};
    endfunction

    function automatic logic [tag_width-1:0] tag_of(pix_addr_t a);
        return {a.field.blk_y[blk_addr_y_width-1:line_y_width],
                a.field.blk_x[blk_addr_x_width-1:line_x_width]};
    endfunction

endpackage

// File: src/texcache_r_combiner.sv
module texcache_r_combiner import texcache_pkg::*; (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [component_num*component_width-1:0] s_data,
    input  logic [component_num-1:0]                 s_last,
    input  logic [component_num-1:0]                 s_valid,
    input  logic                                     m_ready,
    output logic [component_num-1:0]                 s_ready,
    output logic [pixel_width-1:0]                   m_data,
    output logic                                     m_last,
    output logic                                     m_valid
);

    logic pop;

    // all components present and output slot free or draining
    assign pop     = (&s_valid) && (!m_valid || m_ready);
    assign s_ready = {component_num{pop}};

    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid <= 1'b0;
        end else if (pop) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    // components of one pixel carry the same last flag
    always_ff @(posedge clk) begin
        if (pop) begin
            m_data <= s_data;
            m_last <= s_last[0];
        end
    end

endmodule

// File: src/texcache_r_fifo.sv
module texcache_r_fifo import texcache_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [component_width-1:0] s_data,
    input  logic                       s_last,
    input  logic                       s_valid,
    input  logic                       m_ready,
    output logic                       s_ready,
    output logic [component_width-1:0] m_data,
    output logic                       m_last,
    output logic                       m_valid
);

    logic [component_width-1:0]     data_mem [r_fifo_depth];
    logic                           last_mem [r_fifo_depth];
    logic [$clog2(r_fifo_depth):0]  wr_ptr;
    logic [$clog2(r_fifo_depth):0]  rd_ptr;

    assign s_ready = ((wr_ptr - rd_ptr) != ($clog2(r_fifo_depth) + 1)'(r_fifo_depth));
    assign m_valid = (wr_ptr != rd_ptr);

    // first word falls through
    assign m_data  = data_mem[rd_ptr[$clog2(r_fifo_depth)-1:0]];
    assign m_last  = last_mem[rd_ptr[$clog2(r_fifo_depth)-1:0]];

    always_ff @(posedge clk) begin
        if (s_valid && s_ready) begin
            data_mem[wr_ptr[$clog2(r_fifo_depth)-1:0]] <= s_data;
            last_mem[wr_ptr[$clog2(r_fifo_depth)-1:0]] <= s_last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (s_valid && s_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (m_valid && m_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: src/texcache_tag.sv
module texcache_tag import texcache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      clear_start,
    input  pix_addr_t s_araddr,
    input  logic      s_arvalid,
    input  logic      m_ready,
    input  logic      miss_ready,
    output logic      s_arready,
    output logic      clear_busy,
    output pix_addr_t m_addr,
    output logic      m_hit,
    output logic      m_valid,
    output pix_addr_t miss_addr,
    output logic      miss_valid,
    output logic      status_hit,
    output logic      status_miss
);

    logic [tag_width-1:0]           tag_mem [1 << tag_addr_width];
    logic [(1 << tag_addr_width)-1:0] tag_valid;
    logic [tag_addr_width-1:0]      clear_cnt;
    logic [tag_addr_width-1:0]      in_line;
    pix_addr_t                      out_addr;
    logic                           out_hit;
    logic                           out_valid;
    logic                           lookup_hit;
    logic                           accept;
    logic                           take;

    assign in_line    = line_of(s_araddr);
    assign lookup_hit = tag_valid[in_line] && (tag_mem[in_line] == tag_of(s_araddr));

    // a miss leaves only together with its block request
    assign m_valid    = out_valid && (out_hit || miss_ready);
    assign miss_valid = out_valid && !out_hit && m_ready;
    assign take       = m_valid && m_ready;
    assign s_arready  = !clear_busy && (!out_valid || take);
    assign accept     = s_arvalid && s_arready;

    assign m_addr      = out_addr;
    assign m_hit       = out_hit;
    assign status_hit  = take && out_hit;
    assign status_miss = take && !out_hit;

    always_comb begin
        miss_addr = out_addr;
        miss_addr.field.pix_x = '0;
        miss_addr.field.pix_y = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            clear_busy <= 1'b0;
            clear_cnt  <= '0;
            tag_valid  <= '0;
        end else begin
            if (take) begin
                out_valid <= 1'b0;
            end
            if (accept) begin
                out_valid <= 1'b1;
                if (!lookup_hit) begin
                    tag_valid[in_line] <= 1'b1;
                end
            end
            // ------------------------------------------------------------
            // clear sequencer walks one line per cycle
            // ------------------------------------------------------------
            if (clear_busy) begin
                tag_valid[clear_cnt] <= 1'b0;
                clear_cnt <= clear_cnt + 1'b1;
                if (&clear_cnt) begin
                    clear_busy <= 1'b0;
                end
            end else if (clear_start) begin
                clear_busy <= 1'b1;
                clear_cnt  <= '0;
            end
        end
    end

    // tag written at lookup since the fill always follows
    always_ff @(posedge clk) begin
        if (accept) begin
            out_addr <= s_araddr;
            out_hit  <= lookup_hit;
            if (!lookup_hit) begin
                tag_mem[in_line] <= tag_of(s_araddr);
            end
        end
    end

endmodule

// File: tb/texcache_asserts.sv
module texcache_asserts import texcache_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clear_busy,
    input  logic                     status_hit,
    input  logic                     status_miss,
    input  pix_addr_t                s_araddr,
    input  logic                     s_arvalid,
    input  logic                     s_arready,
    input  logic [pixel_width-1:0]   s_rdata,
    input  logic                     s_rvalid,
    input  logic                     s_rready,
    input  pix_addr_t                m_araddr,
    input  logic                     m_arvalid,
    input  logic                     m_arready,
    input  logic [component_num-1:0] m_rstrb,
    input  logic                     m_rlast,
    input  logic                     m_rvalid,
    input  logic                     m_rready
);
    timeunit 1ns;
    timeprecision 100ps;

    int                     fail_cnt = 0;
    logic                   sh_valid [16];
    logic [tag_width-1:0]   sh_tag [16];
    logic [(1 << (blk_addr_x_width + blk_addr_y_width))-1:0] fresh;
    logic [15:0]            acc_addr [64];
    logic                   acc_hit [64];
    logic                   acc_fresh [64];
    logic [5:0]             acc_wr;
    logic [5:0]             st_rd;
    logic [5:0]             rd_rd;
    logic [15:0]            miss_org [64];
    logic [5:0]             miss_wr;
    logic [5:0]             miss_rd;
    int                     ar_cnt;
    int                     done_cnt;
    logic [2:0]             strb_seen;
    logic                   accept;
    logic [3:0]             in_line;
    logic [tag_width-1:0]   in_tag;
    logic [blk_addr_x_width+blk_addr_y_width-1:0] in_blk;
    logic [15:0]            rd_head;
    logic [pixel_width-1:0] exp_pix;
    logic                   exp_hit;
    logic                   exp_fresh;
    logic [15:0]            exp_org;
    logic [2:0]             strb_all;

    // line from the low block bits and tag from the rest
    assign accept    = s_arvalid && s_arready;
    assign in_line   = {s_araddr.raw.y[2:1], s_araddr.raw.x[2:1]};
    assign in_tag    = {s_araddr.raw.y[7:3], s_araddr.raw.x[7:3]};
    assign in_blk    = {s_araddr.raw.y[7:1], s_araddr.raw.x[7:1]};
    assign rd_head   = acc_addr[rd_rd];
    assign exp_pix   = {rd_head[15:8] ^ rd_head[7:0], rd_head[15:8], rd_head[7:0]};
    assign exp_hit   = acc_hit[st_rd];
    assign exp_fresh = acc_fresh[st_rd];
    assign exp_org   = miss_org[miss_rd];
    assign strb_all  = strb_seen | m_rstrb;

    // ------------------------------------------------------------
    // shadow tags and access order
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                sh_valid[i] <= 1'b0;
            end
            fresh     <= '1;
            acc_wr    <= '0;
            st_rd     <= '0;
            rd_rd     <= '0;
            miss_wr   <= '0;
            miss_rd   <= '0;
            ar_cnt    <= 0;
            done_cnt  <= 0;
            strb_seen <= '0;
        end else begin
            if (clear_busy) begin
                for (int i = 0; i < 16; i++) begin
                    sh_valid[i] <= 1'b0;
                end
                fresh <= '1;
            end
            if (accept) begin
                acc_addr[acc_wr]  <= s_araddr;
                acc_hit[acc_wr]   <= sh_valid[in_line] && (sh_tag[in_line] == in_tag);
                acc_fresh[acc_wr] <= fresh[in_blk];
                sh_valid[in_line] <= 1'b1;
                sh_tag[in_line]   <= in_tag;
                fresh[in_blk]     <= 1'b0;
                acc_wr            <= acc_wr + 1'b1;
            end
            if (status_hit || status_miss) begin
                st_rd <= st_rd + 1'b1;
            end
            if (status_miss) begin
                miss_org[miss_wr] <= acc_addr[st_rd] & 16'hfefe;
                miss_wr           <= miss_wr + 1'b1;
            end
            if (s_rvalid && s_rready) begin
                rd_rd <= rd_rd + 1'b1;
            end
            if (m_arvalid && m_arready) begin
                miss_rd <= miss_rd + 1'b1;
                ar_cnt  <= ar_cnt + 1;
            end
            // a block ends on the beat that completes its last pixel
            if (m_rvalid && m_rready) begin
                if (strb_all == 3'b111) begin
                    strb_seen <= '0;
                    if (m_rlast) begin
                        done_cnt <= done_cnt + 1;
                    end
                end else begin
                    strb_seen <= strb_all;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    a_rdata: assert property (@(posedge clk) disable iff (reset)
        s_rvalid && s_rready |-> s_rdata == exp_pix)
    else begin
        fail_cnt++;
        $error("ERR s_rdata %h expected %h", $sampled(s_rdata), $sampled(exp_pix));
    end

    a_status: assert property (@(posedge clk) disable iff (reset)
        (status_hit || status_miss) |-> status_hit == exp_hit)
    else begin
        fail_cnt++;
        $error("ERR status_hit %h expected %h", $sampled(status_hit), $sampled(exp_hit));
    end

    a_fresh: assert property (@(posedge clk) disable iff (reset)
        status_hit |-> !exp_fresh)
    else begin
        fail_cnt++;
        $error("hit reported on the first access to a block after a clear");
    end

    a_miss_pending: assert property (@(posedge clk) disable iff (reset)
        m_arvalid && m_arready |-> miss_rd != miss_wr)
    else begin
        fail_cnt++;
        $error("block read issued with no miss waiting for it");
    end

    a_miss_addr: assert property (@(posedge clk) disable iff (reset)
        m_arvalid && m_arready && (miss_rd != miss_wr) |-> m_araddr == exp_org)
    else begin
        fail_cnt++;
        $error("ERR m_araddr %h expected %h", $sampled(m_araddr), $sampled(exp_org));
    end

    a_limit: assert property (@(posedge clk) disable iff (reset)
        (ar_cnt - done_cnt) <= look_ahead_num)
    else begin
        fail_cnt++;
        $error("too many block reads outstanding on the memory port");
    end

    a_stable: assert property (@(posedge clk) disable iff (reset)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
    else begin
        fail_cnt++;
        $error("read data changed or dropped while stalled");
    end

    a_reset: assert property (@(posedge clk)
        $fell(reset) |-> !s_rvalid && !m_arvalid && !clear_busy)
    else begin
        fail_cnt++;
        $error("outputs not idle in the cycle after reset");
    end

endmodule

// File: tb/texcache_tb.sv
module texcache_tb import texcache_pkg::*; ;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int access_num     = 150;
    localparam int timeout_cycles = 2000;

    logic                     clk;
    logic                     reset;
    logic                     clear_start;
    logic                     clear_busy;
    logic                     status_hit;
    logic                     status_miss;
    pix_addr_t                s_araddr;
    logic                     s_arvalid;
    logic                     s_arready;
    logic [pixel_width-1:0]   s_rdata;
    logic                     s_rvalid;
    logic                     s_rready;
    pix_addr_t                m_araddr;
    logic                     m_arvalid;
    logic                     m_arready;
    logic [pixel_width-1:0]   m_rdata;
    logic [component_num-1:0] m_rstrb;
    logic                     m_rlast;
    logic                     m_rvalid;
    logic                     m_rready;

    logic [31:0] lfsr_state = 32'h0502f8cc;
    pix_addr_t   req_q [$];
    int          reads_done = 0;

    texcache_lookahead UUT (.*);

    bind texcache_lookahead texcache_asserts u_asserts (.*);

    always #10 clk = ~clk;

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic stop_on_timeout(input int cycles, input string what);
        if (cycles >= timeout_cycles) begin
            $display("Testbench failed");
            $fatal(1, "timeout while waiting for %s", what);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_access(input pix_addr_t a);
        int   cycles;
        logic done;
        cycles    = 0;
        done      = 1'b0;
        s_araddr  = a;
        s_arvalid = 1'b1;
        while (!done) begin
            @(negedge clk);
            done = s_arready;
            @(posedge clk);
            #1;
            cycles++;
            stop_on_timeout(cycles, "s_arready");
        end
        s_arvalid = 1'b0;
    endtask

    task automatic run_clear();
        int   cycles;
        logic busy;
        cycles      = 0;
        clear_start = 1'b1;
        idle_cycles(1);
        clear_start = 1'b0;
        do begin
            @(negedge clk);
            busy = clear_busy;
            @(posedge clk);
            #1;
            cycles++;
            stop_on_timeout(cycles, "the end of a clear");
        end while (busy);
    endtask

    // small window so lines see hits and evictions
    task automatic drive_accesses();
        pix_addr_t   a;
        logic [31:0] r;
        for (int i = 0; i < access_num; i++) begin
            if (i == 50 || i == 100) begin
                run_clear();
            end
            r = rand_bits(8);
            a.raw.x = {4'h0, r[3:0]};
            a.raw.y = {4'h0, r[7:4]};
            send_access(a);
            idle_cycles(rand_bits(2) == 0 ? 1 : 0);
        end
    endtask

    task automatic collect_reads();
        int cycles;
        cycles = 0;
        while (reads_done < access_num) begin
            s_rready = (rand_bits(2) != 0);
            @(negedge clk);
            if (s_rvalid && s_rready) begin
                reads_done++;
                cycles = 0;
            end else begin
                cycles++;
            end
            stop_on_timeout(cycles, "read data");
            @(posedge clk);
            #1;
        end
        s_rready = 1'b0;
    endtask

    // ------------------------------------------------------------
    // memory model
    // ------------------------------------------------------------
    task automatic accept_mem_addr();
        forever begin
            m_arready = (rand_bits(1) != 0);
            @(negedge clk);
            if (m_arvalid && m_arready) begin
                req_q.push_back(m_araddr);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic return_mem_data();
        pix_addr_t   org;
        logic [7:0]  px;
        logic [7:0]  py;
        logic [2:0]  remaining;
        logic [2:0]  strb;
        logic [31:0] r;
        int          cycles;
        logic        done;
        forever begin
            cycles = 0;
            while (req_q.size() == 0) begin
                idle_cycles(1);
                cycles++;
                stop_on_timeout(cycles, "a memory request");
            end
            org = req_q.pop_front();
            for (int p = 0; p < blk_pix_num; p++) begin
                px        = org.raw.x + 8'(p % 2);
                py        = org.raw.y + 8'(p / 2);
                remaining = 3'b111;
                while (remaining != 0) begin
                    idle_cycles(rand_bits(1));
                    r    = rand_bits(3);
                    strb = r[2:0] & remaining;
                    if (strb == 0) begin
                        strb = remaining;
                    end
                    m_rdata  = {px ^ py, py, px};
                    m_rstrb  = strb;
                    m_rlast  = (p == blk_pix_num - 1);
                    m_rvalid = 1'b1;
                    cycles   = 0;
                    done     = 1'b0;
                    while (!done) begin
                        @(negedge clk);
                        done = m_rready;
                        @(posedge clk);
                        #1;
                        cycles++;
                        stop_on_timeout(cycles, "m_rready");
                    end
                    m_rvalid  = 1'b0;
                    remaining = remaining & ~strb;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (UUT.u_asserts.fail_cnt != 0) begin
            $display("Testbench failed");
            $fatal(1, "an assertion check failed");
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        clear_start = 1'b0;
        s_araddr    = '0;
        s_arvalid   = 1'b0;
        s_rready    = 1'b0;
        m_arready   = 1'b0;
        m_rdata     = '0;
        m_rstrb     = '0;
        m_rlast     = 1'b0;
        m_rvalid    = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        fork
            accept_mem_addr();
            return_mem_data();
        join_none
        fork
            drive_accesses();
            collect_reads();
        join
        idle_cycles(2);
        if (UUT.u_asserts.fail_cnt == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "assertion checks failed");
        end
    end

endmodule
